//--- common/imuldiv_settings.svh
// fixed datapath sizes for the iterative mul/div unit
// the order queue depth must be a power of two
`ifndef IMULDIV_SETTINGS_SVH
`define IMULDIV_SETTINGS_SVH

// ----------------------------------------
// datapath
// ----------------------------------------

// operand width, results are twice as wide
`define IMULDIV_XLEN 32

// one shift step per operand bit
`define IMULDIV_ITERS 32

// ----------------------------------------
// response ordering
// ----------------------------------------

// also the max number of operations in flight
`define IMULDIV_ORDER_DEPTH 2

`endif

//--- common/imuldiv_pkg.sv
// types shared by the mul/div datapaths, the top and the testbench
// function code 3 is reserved and handled as an unsigned divide
`include "imuldiv_settings.svh"

package imuldiv_pkg;

  // ----------------------------------------
  // request function
  // ----------------------------------------
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } imuldiv_fn_e;

  // ----------------------------------------
  // result word
  // ----------------------------------------

  // divide view, remainder sits in the upper half
  typedef struct packed {
    logic [`IMULDIV_XLEN-1:0] rem;
    logic [`IMULDIV_XLEN-1:0] quot;
  } imuldiv_divrem_s;

  // same 64 bits, read as product or as rem/quot
  typedef union packed {
    logic signed [2*`IMULDIV_XLEN-1:0] product;
    imuldiv_divrem_s                   divrem;
  } imuldiv_result_u;

endpackage

//--- common/imuldiv_req_if.sv
// request channel from the top to one arithmetic unit
// a transfer happens on an edge with val and rdy both high
`include "imuldiv_settings.svh"

interface imuldiv_req_if;

  // handshake
  logic val;
  logic rdy;

  // operands, held by the top while val is high
  logic [`IMULDIV_XLEN-1:0] a;
  logic [`IMULDIV_XLEN-1:0] b;

  // signed divide, the multiplier ignores it
  logic is_signed;

  // top side
  modport issue (
    output val,
    output a,
    output b,
    output is_signed,
    input  rdy
  );

  // arithmetic unit side
  modport unit (
    input  val,
    input  a,
    input  b,
    input  is_signed,
    output rdy
  );

endinterface

//--- hw/mul/imuldiv_mul_dpath.sv
// shift-and-add over operand magnitudes, then one sign-fix cycle
// result is valid only after fix, it is not cleared by reset
`include "imuldiv_settings.svh"

module imuldiv_mul_dpath
  import imuldiv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`IMULDIV_XLEN-1:0] a,
  input  logic [`IMULDIV_XLEN-1:0] b,
  input  logic                     load,
  input  logic                     step,
  input  logic                     fix,
  output logic                     last_step,
  output imuldiv_result_u          result
);

  localparam int xlen  = `IMULDIV_XLEN;
  localparam int cnt_w = $clog2(`IMULDIV_ITERS);

  // magnitudes of the incoming operands
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;

  // multiplicand widens as it shifts left
  logic [2*xlen-1:0] mcand_q;
  logic [xlen-1:0]   mplier_q;
  logic [2*xlen-1:0] acc_q;
  logic              neg_q;
  logic [cnt_w-1:0]  cnt_q;

  // most negative value maps to 2^31, still correct as unsigned
  assign a_mag = a[xlen-1] ? (~a + 1'b1) : a;
  assign b_mag = b[xlen-1] ? (~b + 1'b1) : b;

  // ----------------------------------------
  // step counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= cnt_w'(`IMULDIV_ITERS - 1);
    end else if (step) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // counter reads zero during the final step
  assign last_step = (cnt_q == '0);

  // ----------------------------------------
  // operand shifters and accumulator
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (load) begin
      mcand_q  <= {{xlen{1'b0}}, a_mag};
      mplier_q <= b_mag;
      acc_q    <= '0;
      neg_q    <= a[xlen-1] ^ b[xlen-1];
    end else if (step) begin
      // add only for a set multiplier bit
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= {mcand_q[2*xlen-2:0], 1'b0};
      mplier_q <= {1'b0, mplier_q[xlen-1:1]};
    end else if (fix && neg_q) begin
      acc_q <= ~acc_q + 1'b1;
    end
  end

  assign result.product = acc_q;

endmodule

//--- hw/mul/imuldiv_mul_iterative.sv
// iterative signed multiplier, fixed latency, no early exit
// one request at a time, rdy only while idle
`include "imuldiv_settings.svh"

module imuldiv_mul_iterative
  import imuldiv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  imuldiv_req_if.unit     req,
  output logic            resp_val,
  input  logic            resp_rdy,
  output imuldiv_result_u resp_result
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_fix,
    st_done
  } state_e;

  state_e state;
  state_e state_next;

  logic load;
  logic step;
  logic fix;
  logic last_step;

  // ----------------------------------------
  // control FSM
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      // load happens on the accepting edge
      st_idle: if (req.val) state_next = st_calc;
      // count hits zero on the 32nd step
      st_calc: if (last_step) state_next = st_fix;
      st_fix:  state_next = st_done;
      // hold the result until the top takes it
      st_done: if (resp_rdy) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  // handshakes and datapath enables
  assign req.rdy  = (state == st_idle);
  assign load     = req.val && req.rdy;
  assign step     = (state == st_calc);
  assign fix      = (state == st_fix);
  assign resp_val = (state == st_done);

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  imuldiv_mul_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .a         (req.a),
    .b         (req.b),
    .load      (load),
    .step      (step),
    .fix       (fix),
    .last_step (last_step),
    .result    (resp_result)
  );

endmodule

//--- hw/div/imuldiv_div_dpath.sv
// restoring division over magnitudes, truncating toward zero
// divide by zero gives all-ones quotient and the dividend as remainder
`include "imuldiv_settings.svh"

module imuldiv_div_dpath
  import imuldiv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic [`IMULDIV_XLEN-1:0] a,
  input  logic [`IMULDIV_XLEN-1:0] b,
  input  logic                     is_signed,
  input  logic                     load,
  input  logic                     step,
  input  logic                     fix,
  output logic                     last_step,
  output imuldiv_result_u          result
);

  localparam int xlen  = `IMULDIV_XLEN;
  localparam int cnt_w = $clog2(`IMULDIV_ITERS);

  logic a_neg;
  logic b_neg;
  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;

  // remainder in the upper half, dividend/quotient in the lower half
  logic [2*xlen-1:0] rq_q;
  logic [xlen-1:0]   divisor_q;
  logic              neg_quot_q;
  logic              neg_rem_q;
  logic              div_zero_q;
  logic [cnt_w-1:0]  cnt_q;

  // trial subtract, one extra bit for the shifted-out remainder msb
  logic [xlen:0]   rem_up;
  logic [xlen:0]   trial;
  logic [xlen-1:0] quot_fix;
  logic [xlen-1:0] rem_fix;

  // raw operands for divu
  assign a_neg = is_signed && a[xlen-1];
  assign b_neg = is_signed && b[xlen-1];
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  // ----------------------------------------
  // step counter
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (load) begin
      cnt_q <= cnt_w'(`IMULDIV_ITERS - 1);
    end else if (step) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign last_step = (cnt_q == '0);

  // ----------------------------------------
  // shift-subtract and sign fix
  // ----------------------------------------

  assign rem_up = rq_q[2*xlen-1:xlen-1];
  assign trial  = rem_up - {1'b0, divisor_q};

  // a zero divisor never fails the trial, so the remainder ends as |a|
  // and the remainder sign rule turns it back into the dividend
  assign quot_fix = div_zero_q ? '1 :
                    (neg_quot_q ? (~rq_q[xlen-1:0] + 1'b1) : rq_q[xlen-1:0]);
  assign rem_fix  = neg_rem_q ? (~rq_q[2*xlen-1:xlen] + 1'b1) : rq_q[2*xlen-1:xlen];

  always_ff @(posedge clk) begin
    if (load) begin
      rq_q       <= {{xlen{1'b0}}, a_mag};
      divisor_q  <= b_mag;
      neg_quot_q <= a_neg ^ b_neg;
      neg_rem_q  <= a_neg;
      div_zero_q <= (b == '0);
    end else if (step) begin
      if (!trial[xlen]) begin
        // trial fits, keep the difference and set the quotient bit
        rq_q <= {trial[xlen-1:0], rq_q[xlen-2:0], 1'b1};
      end else begin
        // restore, plain shift with a zero quotient bit
        rq_q <= {rq_q[2*xlen-2:0], 1'b0};
      end
    end else if (fix) begin
      rq_q <= {rem_fix, quot_fix};
    end
  end

  assign result.divrem = '{rem: rq_q[2*xlen-1:xlen], quot: rq_q[xlen-1:0]};

endmodule

//--- hw/div/imuldiv_div_iterative.sv
// iterative divider, signed or unsigned per request
// same fixed latency as the multiplier, rdy only while idle
`include "imuldiv_settings.svh"

module imuldiv_div_iterative
  import imuldiv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  imuldiv_req_if.unit     req,
  output logic            resp_val,
  input  logic            resp_rdy,
  output imuldiv_result_u resp_result
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_fix,
    st_done
  } state_e;

  state_e state;
  state_e state_next;

  logic load;
  logic step;
  logic fix;
  logic last_step;

  // ----------------------------------------
  // control FSM
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: if (req.val) state_next = st_calc;
      // 32 restoring steps, then the sign fix
      st_calc: if (last_step) state_next = st_fix;
      st_fix:  state_next = st_done;
      st_done: if (resp_rdy) state_next = st_idle;
      default: state_next = st_idle;
    endcase
  end

  assign req.rdy  = (state == st_idle);
  assign load     = req.val && req.rdy;
  assign step     = (state == st_calc);
  assign fix      = (state == st_fix);
  assign resp_val = (state == st_done);

  // ----------------------------------------
  // datapath
  // ----------------------------------------

  // is_signed only matters on the load edge
  imuldiv_div_dpath dpath (
    .clk       (clk),
    .reset     (reset),
    .a         (req.a),
    .b         (req.b),
    .is_signed (req.is_signed),
    .load      (load),
    .step      (step),
    .fix       (fix),
    .last_step (last_step),
    .result    (resp_result)
  );

endmodule

//--- hw/imuldiv_iterative.sv
// mul/div top where one multiply and one divide may be in flight together
// responses leave in request order through an order queue of unit tags
`include "imuldiv_settings.svh"

module imuldiv_iterative
  import imuldiv_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  imuldiv_fn_e              req_fn,
  input  logic [`IMULDIV_XLEN-1:0] req_a,
  input  logic [`IMULDIV_XLEN-1:0] req_b,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output imuldiv_result_u          resp_result
);

  localparam int depth = `IMULDIV_ORDER_DEPTH;
  localparam int ptr_w = $clog2(depth);

  imuldiv_req_if mul_req ();
  imuldiv_req_if div_req ();

  logic            req_is_div;
  logic            push;
  logic            pop;
  logic            q_full;
  logic            q_empty;
  logic            head_is_div;
  logic            mul_resp_val;
  logic            mul_resp_rdy;
  logic            div_resp_val;
  logic            div_resp_rdy;
  imuldiv_result_u mul_resp_result;
  imuldiv_result_u div_resp_result;

  // order queue of unit tags where a set tag means the divider
  logic             tag_mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   q_count;

  // ----------------------------------------
  // dispatch
  // ----------------------------------------

  // reserved code 3 falls through to divu
  assign req_is_div = (req_fn != fn_mul);

  // val goes to the selected unit only and never while the queue is full
  assign mul_req.val       = req_val && !req_is_div && !q_full;
  assign mul_req.a         = req_a;
  assign mul_req.b         = req_b;
  assign mul_req.is_signed = (req_fn == fn_div);

  assign div_req.val       = req_val && req_is_div && !q_full;
  assign div_req.a         = req_a;
  assign div_req.b         = req_b;
  assign div_req.is_signed = (req_fn == fn_div);

  assign req_rdy = (req_is_div ? div_req.rdy : mul_req.rdy) && !q_full;
  assign push    = req_val && req_rdy;

  // ----------------------------------------
  // order queue
  // ----------------------------------------

  assign q_full      = (q_count == (ptr_w+1)'(depth));
  assign q_empty     = (q_count == '0);
  assign head_is_div = tag_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      tag_mem[wr_ptr] <= req_is_div;
    end
  end

  // pointers wrap naturally because depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   q_count <= q_count + 1'b1;
        2'b01:   q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
    end
  end

  // ----------------------------------------
  // response mux for the head of the queue only
  // ----------------------------------------

  assign resp_val     = !q_empty && (head_is_div ? div_resp_val : mul_resp_val);
  assign resp_result  = head_is_div ? div_resp_result : mul_resp_result;
  assign mul_resp_rdy = resp_rdy && !q_empty && !head_is_div;
  assign div_resp_rdy = resp_rdy && !q_empty && head_is_div;
  assign pop          = resp_val && resp_rdy;

  imuldiv_mul_iterative mul0 (
    .clk         (clk),
    .reset       (reset),
    .req         (mul_req),
    .resp_val    (mul_resp_val),
    .resp_rdy    (mul_resp_rdy),
    .resp_result (mul_resp_result)
  );

  imuldiv_div_iterative div0 (
    .clk         (clk),
    .reset       (reset),
    .req         (div_req),
    .resp_val    (div_resp_val),
    .resp_rdy    (div_resp_rdy),
    .resp_result (div_resp_result)
  );

endmodule

//--- verification/tb_clock_gen.sv
// testbench clock and reset, period 4 time units
// reset is high for the first 16 rising edges
module tb_clock_gen (
  output logic clk,
  output logic reset
);

  localparam int half_period  = 2;
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // release on a rising edge, the DUT still sees reset on that edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- verification/tb_imuldiv.sv
// testbench for the iterative mul/div top, checks are concurrent assertions
// assumes a fixed latency of ITERS+2 edges and responses in request order
`include "imuldiv_settings.svh"

module tb_imuldiv
  import imuldiv_pkg::*;
();

  localparam int clk_period = 4;
  localparam int latency    = `IMULDIV_ITERS + 2;
  localparam int n_corner   = 7;
  localparam int n_rand     = 16;
  localparam int n_zero     = 6;
  localparam int n_rounds   = 4;
  localparam int n_bp       = 24;
  localparam int total_ops  = 3 * n_corner * n_corner + 3 * n_rand + 2 * n_zero
                              + 4 * n_rounds + n_bp;
  // each op at full latency, plus room for back-pressure and stalls
  localparam int watchdog_cycles = 16 + total_ops * latency + total_ops * 16 + 200;

  logic            clk;
  logic            reset;
  logic            req_val;
  logic            req_rdy;
  imuldiv_fn_e     req_fn;
  logic [31:0]     req_a;
  logic [31:0]     req_b;
  logic            resp_val;
  logic            resp_rdy = 1'b1;
  imuldiv_result_u resp_result;

  // reference model state, one slot per request in order
  imuldiv_result_u exp_mem [256];
  logic            exp_is_div [256];
  logic [7:0]      exp_wr;
  logic [7:0]      exp_rd;
  imuldiv_result_u exp_head;
  logic            head_is_div;
  int              in_flight;
  int              sent_total;
  int              recv_total;
  int              age;
  int              err_count = 0;
  int              mark_errs = 0;
  int              mark_ops = 0;
  logic            mul_busy;
  logic            div_busy;
  logic            timed;
  logic            exp_rdy;
  logic            accept;
  logic            take;
  logic            held_val;
  imuldiv_result_u held_result;
  logic [31:0]     lfsr = 32'hf64a_dc7d;
  logic            bp_mode = 1'b0;
  logic [3:0]      bp_hold = '0;
  logic [31:0]     corner [n_corner] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000,
                                         32'h7fff_ffff, 32'h7, 32'hffff_fffe};

  tb_clock_gen clk_gen0 (
    .clk   (clk),
    .reset (reset)
  );

  imuldiv_iterative dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] val;
    int i;
    val = '0;
    for (i = 0; i < nbits; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return val;
  endfunction

  // truncating division, remainder keeps the dividend sign
  function automatic imuldiv_result_u expected_result(input imuldiv_fn_e fn,
                                                      input logic [31:0] a,
                                                      input logic [31:0] b);
    imuldiv_result_u r;
    longint sa;
    longint sb;
    longint q;
    longint m;
    if (fn == fn_div) begin
      sa = longint'($signed(a));
      sb = longint'($signed(b));
    end else begin
      sa = longint'({32'h0, a});
      sb = longint'({32'h0, b});
    end
    if (fn == fn_mul) begin
      r.product = longint'($signed(a)) * longint'($signed(b));
    end else if (b == '0) begin
      // divide by zero
      r.divrem.quot = '1;
      r.divrem.rem  = a;
    end else begin
      q = sa / sb;
      m = sa % sb;
      r.divrem.quot = q[31:0];
      r.divrem.rem  = m[31:0];
    end
    return r;
  endfunction

  task automatic flag_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] want);
    $display("[ERROR] t=%0t %s: got %0h expected %0h", $time, name, got, want);
    err_count++;
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send(input imuldiv_fn_e fn, input logic [31:0] a, input logic [31:0] b);
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    do @(posedge clk); while (!req_rdy);
    @(negedge clk);
    req_val = 1'b0;
  endtask

  task automatic close_test(input string name);
    wait (recv_total == sent_total);
    @(negedge clk);
    $display("test %-14s %4d ops  %0d errors", name, sent_total - mark_ops,
             err_count - mark_errs);
    mark_errs = err_count;
    mark_ops  = sent_total;
  endtask

  // ----------------------------------------
  // reference model and bookkeeping
  // ----------------------------------------

  assign accept      = req_val && req_rdy;
  assign take        = resp_val && resp_rdy;
  assign exp_head    = exp_mem[exp_rd];
  assign head_is_div = exp_is_div[exp_rd];
  // unit must be idle and the order queue not full
  assign exp_rdy = !((req_fn == fn_mul) ? mul_busy : div_busy)
                   && (in_flight < `IMULDIV_ORDER_DEPTH);

  always @(posedge clk) begin
    if (reset) begin
      exp_wr     <= '0;
      exp_rd     <= '0;
      in_flight  <= 0;
      sent_total <= 0;
      recv_total <= 0;
      mul_busy   <= 1'b0;
      div_busy   <= 1'b0;
      timed      <= 1'b0;
      age        <= 0;
      held_val   <= 1'b0;
    end else begin
      held_val    <= resp_val && !resp_rdy;
      held_result <= resp_result;
      if (timed) age <= age + 1;
      if (take) begin
        exp_rd     <= exp_rd + 1'b1;
        recv_total <= recv_total + 1;
        timed      <= 1'b0;
        if (head_is_div) div_busy <= 1'b0;
        else mul_busy <= 1'b0;
      end
      if (accept) begin
        exp_mem[exp_wr]    <= expected_result(req_fn, req_a, req_b);
        exp_is_div[exp_wr] <= (req_fn != fn_mul);
        exp_wr             <= exp_wr + 1'b1;
        sent_total         <= sent_total + 1;
        if (req_fn == fn_mul) mul_busy <= 1'b1;
        else div_busy <= 1'b1;
        // latency is fixed only with nothing ahead in the queue
        if (in_flight == 0) begin
          timed <= 1'b1;
          age   <= 1;
        end
      end
      in_flight <= in_flight + (accept ? 1 : 0) - (take ? 1 : 0);
    end
  end

  // response back-pressure, random low periods of up to 15 cycles
  always @(negedge clk) begin
    if (!bp_mode) begin
      resp_rdy <= 1'b1;
    end else if (bp_hold != '0) begin
      resp_rdy <= 1'b0;
      bp_hold  <= bp_hold - 1'b1;
    end else begin
      resp_rdy <= 1'b1;
      bp_hold  <= 4'(rand_bits(4));
    end
  end

  // ----------------------------------------
  // assertions
  // ----------------------------------------

  rdy_rule: assert property (@(posedge clk) disable iff (reset) req_rdy == exp_rdy)
    else flag_mismatch("req_rdy", 64'($sampled(req_rdy)), 64'($sampled(exp_rdy)));
  idle_rule: assert property (@(posedge clk) disable iff (reset)
                              in_flight == 0 |-> !resp_val)
    else flag_mismatch("resp_val", 64'($sampled(resp_val)), 64'(0));
  latency_rule: assert property (@(posedge clk) disable iff (reset)
                                 timed |-> resp_val == (age >= latency))
    else flag_mismatch("resp_val", 64'($sampled(resp_val)), 64'($sampled(age) >= latency));
  product_rule: assert property (@(posedge clk) disable iff (reset)
                                 take && !head_is_div |->
                                 resp_result.product == exp_head.product)
    else flag_mismatch("resp_result.product", $sampled(resp_result.product),
                       $sampled(exp_head.product));
  quot_rule: assert property (@(posedge clk) disable iff (reset)
                              take && head_is_div |->
                              resp_result.divrem.quot == exp_head.divrem.quot)
    else flag_mismatch("resp_result.divrem.quot", 64'($sampled(resp_result.divrem.quot)),
                       64'($sampled(exp_head.divrem.quot)));
  rem_rule: assert property (@(posedge clk) disable iff (reset)
                             take && head_is_div |->
                             resp_result.divrem.rem == exp_head.divrem.rem)
    else flag_mismatch("resp_result.divrem.rem", 64'($sampled(resp_result.divrem.rem)),
                       64'($sampled(exp_head.divrem.rem)));
  // a stalled response keeps its valid and its data
  hold_val_rule: assert property (@(posedge clk) disable iff (reset) held_val |-> resp_val)
    else flag_mismatch("resp_val", 64'($sampled(resp_val)), 64'(1));
  hold_data_rule: assert property (@(posedge clk) disable iff (reset)
                                   held_val |-> resp_result == held_result)
    else flag_mismatch("resp_result", $sampled(resp_result), $sampled(held_result));

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    int i;
    int j;
    logic [31:0] a;
    logic [31:0] b;
    imuldiv_fn_e bp_fn [n_bp];
    logic [31:0] bp_a [n_bp];
    logic [31:0] bp_b [n_bp];
    req_val = 1'b0;
    req_fn  = fn_mul;
    req_a   = '0;
    req_b   = '0;
    wait (!reset);
    @(negedge clk);
    repeat (4) @(negedge clk);
    close_test("reset_state");

    // back to back multiplies, each one sees an empty queue
    for (i = 0; i < n_corner; i++) begin
      for (j = 0; j < n_corner; j++) begin
        send(fn_mul, corner[i], corner[j]);
      end
    end
    for (i = 0; i < n_rand; i++) begin
      a = rand_bits(32);
      b = rand_bits(32);
      send(fn_mul, a, b);
    end
    close_test("mul_signed");

    for (i = 0; i < n_corner; i++) begin
      for (j = 0; j < n_corner; j++) begin
        send(fn_div, corner[i], corner[j]);
        send(fn_divu, corner[i], corner[j]);
      end
    end
    for (i = 0; i < n_rand; i++) begin
      a = rand_bits(32);
      // shorter divisors give larger quotients
      b = rand_bits(32) >> rand_bits(5);
      send(fn_div, a, b);
      send(fn_divu, a, b);
    end
    close_test("div_signs");

    for (i = 0; i < n_zero; i++) begin
      a = (i < 5) ? corner[i] : rand_bits(32);
      send(fn_div, a, '0);
      send(fn_divu, a, '0);
    end
    close_test("div_by_zero");

    // third request stalls behind the busy divider and a full queue
    for (i = 0; i < n_rounds; i++) begin
      a = rand_bits(32);
      b = rand_bits(16);
      send(fn_div, a, b);
      send(fn_mul, b, a);
      send(fn_divu, a, b);
      send(fn_mul, a, a);
    end
    close_test("overlap_order");

    // operands drawn up front, the rdy driver owns the lfsr meanwhile
    for (i = 0; i < n_bp; i++) begin
      bp_fn[i] = imuldiv_fn_e'(rand_bits(2) % 3);
      bp_a[i]  = rand_bits(32);
      bp_b[i]  = rand_bits(32) >> rand_bits(4);
    end
    bp_mode <= 1'b1;
    for (i = 0; i < n_bp; i++) begin
      send(bp_fn[i], bp_a[i], bp_b[i]);
    end
    close_test("back_pressure");
    bp_mode <= 1'b0;

    $display("summary: 6 tests, %0d ops, %0d responses, %0d errors", sent_total,
             recv_total, err_count);
    if (err_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout: %0d of %0d responses returned after %0d cycles", recv_total,
             sent_total, watchdog_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- tb.f
+incdir+common
common/imuldiv_pkg.sv
common/imuldiv_req_if.sv
hw/mul/imuldiv_mul_dpath.sv
hw/mul/imuldiv_mul_iterative.sv
hw/div/imuldiv_div_dpath.sv
hw/div/imuldiv_div_iterative.sv
hw/imuldiv_iterative.sv
verification/tb_clock_gen.sv
verification/tb_imuldiv.sv

//--- Makefile
# Verilator lint and simulation for the iterative mul/div unit
# every variable can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= tb_imuldiv
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FAIL_MSG   ?= Simulation failed
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= --lint-only
BIN        ?= $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the log decides the status, a crash without output also fails
sim: build
	./$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$rc

clean:
	rm -rf $(OBJ_DIR) $(LOG)
